/* design/tictac_defines.svh */
`ifndef TICTAC_DEFINES_SVH
`define TICTAC_DEFINES_SVH

// cells per row and column
`define BOARD_SIDE 3

// one bit per cell in the mark vectors
`define CELLS 9

// cursor index width, enough for 0..8
`define CELL_W 4

// moves down when the board is full
`define MOVE_LIMIT 9

`endif

/* design/tictacPkg.sv */
package tictacPkg;

	typedef enum logic [2:0]
	{
		sInit,  // clear board, centre cursor
		sReady, // waiting for a single button
		sHold,  // waiting for all buttons released
		sWin,
		sDraw
	} gameState_t;

	// decoded button command, one per accepted press
	typedef enum logic [2:0]
	{
		cmdNone,
		cmdUp,
		cmdDown,
		cmdLeft,
		cmdRight,
		cmdPlace
	} command_t;

	typedef enum logic
	{
		markX,
		markO
	} mark_t;

endpackage

/* design/gameIf.sv */
`include "tictac_defines.svh"

interface gameIf import tictacPkg::*;
();

	command_t command;            // valid for one cycle per accepted press
	logic placeReq;
	mark_t turn;
	logic clear;                  // high while in sInit
	logic [`CELL_W-1:0] cursor;
	logic cellFree;               // cursor cell holds no mark
	logic won;
	mark_t winner;
	logic full;

	modport fsm
	(
		output command,
		output placeReq,
		output turn,
		output clear,
		input cellFree,
		input won,
		input winner,
		input full
	);

	modport mover
	(
		input command,
		input clear,
		output cursor
	);

	modport board
	(
		input placeReq,
		input turn,
		input clear,
		input cursor,
		output cellFree,
		output won,
		output winner,
		output full
	);

endinterface

/* design/gameFsm.sv */
module gameFsm import tictacPkg::*;
(
	input logic clk,
	input logic rst,
	input logic up,
	input logic down,
	input logic left,
	input logic right,
	input logic place,
	gameIf.fsm game,
	output gameState_t state
);

	gameState_t nextState;
	command_t rawCmd;
	logic [4:0] buttons;
	logic anyButton;
	logic oneButton;
	logic accept;

	assign buttons = {right, left, down, up, place};
	assign anyButton = |buttons;

	// clearing the lowest set bit leaves nothing only when a single button is down
	assign oneButton = anyButton && ((buttons & (buttons - 5'd1)) == 5'd0);

	always_comb
	begin
		rawCmd = cmdNone;
		if (oneButton)
		begin
			if (right)
				rawCmd = cmdRight;
			else if (left)
				rawCmd = cmdLeft;
			else if (down)
				rawCmd = cmdDown;
			else if (up)
				rawCmd = cmdUp;
			else
				rawCmd = cmdPlace;
		end
	end

	// a place on a taken cell is simply ignored
	assign accept = (state == sReady) && !game.won && !game.full
		&& (rawCmd != cmdNone)
		&& ((rawCmd != cmdPlace) || game.cellFree);

	assign game.command = accept ? rawCmd : cmdNone;
	assign game.placeReq = accept && (rawCmd == cmdPlace);
	assign game.clear = (state == sInit);

	always_comb
	begin
		nextState = state;
		case (state)
			sInit:
				nextState = sReady;
			sReady:
			begin
				if (game.won)
					nextState = sWin;
				else if (game.full)
					nextState = sDraw;
				else if (accept)
					nextState = sHold;
			end
			sHold:
			begin
				if (game.won)
					nextState = sWin;
				else if (game.full)
					nextState = sDraw; // full with no line
				else if (!anyButton)
					nextState = sReady;
			end
			sWin,
			sDraw:
				nextState = state; // only rst gets out
			default:
				nextState = sInit;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= sInit;
			game.turn <= markX;
		end
		else
		begin
			state <= nextState;
			if (state == sInit)
				game.turn <= markX; // X always opens
			else if (game.placeReq)
				game.turn <= (game.turn == markX) ? markO : markX;
		end
	end

endmodule

/* design/cursorMover.sv */
`include "tictac_defines.svh"

module cursorMover import tictacPkg::*;
(
	input logic clk,
	input logic rst,
	gameIf.mover game
);

	logic [`CELL_W-1:0] pos;
	logic [`CELL_W-1:0] nextPos;
	logic leftCol;
	logic rightCol;
	logic bottomRow;
	logic topRow;

	// index 0 is bottom left, rows grow upward
	assign leftCol = (pos == `CELL_W'(0)) || (pos == `CELL_W'(3)) || (pos == `CELL_W'(6));
	assign rightCol = (pos == `CELL_W'(2)) || (pos == `CELL_W'(5)) || (pos == `CELL_W'(8));
	assign bottomRow = pos < `CELL_W'(`BOARD_SIDE);
	assign topRow = pos >= `CELL_W'(2 * `BOARD_SIDE);

	always_comb
	begin
		nextPos = pos;
		case (game.command)
			cmdRight:
			begin
				if (rightCol)
					nextPos = pos - `CELL_W'(`BOARD_SIDE - 1);
				else
					nextPos = pos + `CELL_W'(1);
			end
			cmdLeft:
			begin
				if (leftCol)
					nextPos = pos + `CELL_W'(`BOARD_SIDE - 1);
				else
					nextPos = pos - `CELL_W'(1);
			end
			cmdUp:
			begin
				if (topRow)
					nextPos = pos - `CELL_W'(2 * `BOARD_SIDE); // wrap to bottom row
				else
					nextPos = pos + `CELL_W'(`BOARD_SIDE);
			end
			cmdDown:
			begin
				if (bottomRow)
					nextPos = pos + `CELL_W'(2 * `BOARD_SIDE);
				else
					nextPos = pos - `CELL_W'(`BOARD_SIDE);
			end
			default:
				nextPos = pos; // none or place
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			pos <= `CELL_W'(`CELLS / 2);
		else if (game.clear)
			pos <= `CELL_W'(`CELLS / 2); // back to centre
		else
			pos <= nextPos;
	end

	assign game.cursor = pos;

endmodule

/* design/boardStore.sv */
`include "tictac_defines.svh"

module boardStore import tictacPkg::*;
(
	input logic clk,
	input logic rst,
	gameIf.board game,
	output logic [`CELLS-1:0] xCells,
	output logic [`CELLS-1:0] oCells
);

	logic [3:0] moveCount;
	logic xLine;
	logic oLine;

	// true when any of the eight lines is fully marked
	function automatic logic lineDone(input logic [`CELLS-1:0] c);
		logic rows;
		logic cols;
		logic diags;
		rows = (c[0] & c[1] & c[2])
			| (c[3] & c[4] & c[5])
			| (c[6] & c[7] & c[8]);
		cols = (c[0] & c[3] & c[6])
			| (c[1] & c[4] & c[7])
			| (c[2] & c[5] & c[8]);
		diags = (c[0] & c[4] & c[8]) | (c[2] & c[4] & c[6]);
		return rows | cols | diags;
	endfunction

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			xCells <= '0;
			oCells <= '0;
			moveCount <= '0;
		end
		else if (game.clear)
		begin
			xCells <= '0;
			oCells <= '0;
			moveCount <= '0;
		end
		else if (game.placeReq)
		begin
			if (game.turn == markX)
				xCells[game.cursor] <= 1'b1;
			else
				oCells[game.cursor] <= 1'b1;
			moveCount <= moveCount + 4'd1;
		end
	end

	assign game.cellFree = !(xCells[game.cursor] | oCells[game.cursor]);

	assign xLine = lineDone(xCells);
	assign oLine = lineDone(oCells);

	assign game.won = xLine | oLine;
	assign game.winner = xLine ? markX : markO; // only meaningful with won
	assign game.full = (moveCount == 4'(`MOVE_LIMIT));

endmodule

/* design/ticTacToeTop.sv */
`include "tictac_defines.svh"

module ticTacToeTop import tictacPkg::*;
(
	input logic clk,
	input logic rst,
	input logic up,
	input logic down,
	input logic left,
	input logic right,
	input logic place,
	output logic [`CELL_W-1:0] cursor,
	output logic [`CELLS-1:0] xCells,
	output logic [`CELLS-1:0] oCells,
	output mark_t turn,
	output logic gameWon,
	output logic gameDraw,
	output mark_t winner
);

	gameIf game();

	gameState_t state;

	gameFsm i_fsm
	(
		.clk(clk),
		.rst(rst),
		.up(up),
		.down(down),
		.left(left),
		.right(right),
		.place(place),
		.game(game.fsm),
		.state(state)
	);

	cursorMover i_cursor
	(
		.clk(clk),
		.rst(rst),
		.game(game.mover)
	);

	boardStore i_board
	(
		.clk(clk),
		.rst(rst),
		.game(game.board),
		.xCells(xCells),
		.oCells(oCells)
	);

	// board and cursor go out raw for an external renderer
	assign cursor = game.cursor;
	assign turn = game.turn;
	assign winner = game.winner;

	assign gameWon = (state == sWin);
	assign gameDraw = (state == sDraw);

endmodule

/* test/tictac_checker.sv */
`include "tictac_defines.svh"

module tictacChecker import tictacPkg::*;
(
	input logic clk,
	input logic rst,
	input gameState_t state,
	input logic [`CELL_W-1:0] cursor,
	input logic [`CELLS-1:0] xCells,
	input logic [`CELLS-1:0] oCells
);

	int failures = 0;

	// a cell holds at most one mark
	noSharedCell: assert property (@(posedge clk) disable iff (rst)
		(xCells & oCells) == `CELLS'(0))
	else
	begin
		failures = failures + 1;
		$error("X and O marks share a cell");
	end

	cursorInRange: assert property (@(posedge clk) disable iff (rst)
		cursor < `CELL_W'(`CELLS))
	else
	begin
		failures = failures + 1;
		$error("cursor left the board");
	end

	// board is frozen while waiting for release and after the game ends
	cellsFrozen: assert property (@(posedge clk) disable iff (rst)
		(state == sHold || state == sWin || state == sDraw)
		|=> ($stable(xCells) && $stable(oCells)))
	else
	begin
		failures = failures + 1;
		$error("cell vectors changed outside sReady");
	end

endmodule

/* test/tictacMonitor.sv */
`include "tictac_defines.svh"

module tictacMonitor
(
	input logic clk,
	input logic check,
	input logic [`CELL_W-1:0] expCursor,
	input logic [`CELLS-1:0] expX,
	input logic [`CELLS-1:0] expO,
	input logic expTurn,
	input logic [1:0] expStatus,
	input logic expWinner,
	input logic [`CELL_W-1:0] cursor,
	input logic [`CELLS-1:0] xCells,
	input logic [`CELLS-1:0] oCells,
	input logic turn,
	input logic gameWon,
	input logic gameDraw,
	input logic winner,
	output int mismatches
);

	int count = 0;
	logic [1:0] status;

	assign status = {gameDraw, gameWon}; // 1 won, 2 draw, 3 is never legal
	assign mismatches = count;

	task automatic compareField(input string what, input logic [15:0] got,
		input logic [15:0] expected);
		if (got !== expected)
		begin
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, expected);
			count = count + 1;
		end
	endtask

	// outputs have settled by the falling edge
	always @(negedge clk)
	begin
		if (check)
		begin
			compareField("cursor", 16'(cursor), 16'(expCursor));
			compareField("xCells", 16'(xCells), 16'(expX));
			compareField("oCells", 16'(oCells), 16'(expO));
			compareField("turn", 16'(turn), 16'(expTurn));
			compareField("status", 16'(status), 16'(expStatus));
			if (expStatus == 2'd1)
				compareField("winner", 16'(winner), 16'(expWinner)); // only valid after a win
		end
	end

endmodule

/* test/tictacTb.sv */
`include "tictac_defines.svh"

module tictacTb;

	logic clk;
	logic rst;
	logic up;
	logic down;
	logic left;
	logic right;
	logic place;
	logic [`CELL_W-1:0] cursor;
	logic [`CELLS-1:0] xCells;
	logic [`CELLS-1:0] oCells;
	logic turn;
	logic gameWon;
	logic gameDraw;
	logic winner;

	logic check;
	logic [`CELL_W-1:0] expCursor;
	logic [`CELLS-1:0] expX;
	logic [`CELLS-1:0] expO;
	logic expTurn;
	logic [1:0] expStatus;
	logic expWinner;
	int mismatches;

	string lines[$];
	string testName;
	int limit = 1000;
	int cycles = 0;
	int testsRun = 0;
	int testsPassed = 0;
	int testErrStart = 0;
	int badLines = 0;
	bit inTest = 0;

	ticTacToeTop i_dut
	(
		.clk(clk),
		.rst(rst),
		.up(up),
		.down(down),
		.left(left),
		.right(right),
		.place(place),
		.cursor(cursor),
		.xCells(xCells),
		.oCells(oCells),
		.turn(turn),
		.gameWon(gameWon),
		.gameDraw(gameDraw),
		.winner(winner)
	);

	tictacMonitor i_monitor
	(
		.clk(clk),
		.check(check),
		.expCursor(expCursor),
		.expX(expX),
		.expO(expO),
		.expTurn(expTurn),
		.expStatus(expStatus),
		.expWinner(expWinner),
		.cursor(cursor),
		.xCells(xCells),
		.oCells(oCells),
		.turn(turn),
		.gameWon(gameWon),
		.gameDraw(gameDraw),
		.winner(winner),
		.mismatches(mismatches)
	);

	bind ticTacToeTop tictacChecker i_check
	(
		.clk(clk),
		.rst(rst),
		.state(state),
		.cursor(cursor),
		.xCells(xCells),
		.oCells(oCells)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// run limit scales with the pattern file
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= limit)
		begin
			$display("timeout: simulation did not finish");
			$display("Something failed");
			$finish;
		end
	end

	function automatic int errorTotal();
		return mismatches + i_dut.i_check.failures + badLines;
	endfunction

	task automatic driveButtons(input int btn);
		up <= (btn == 1);
		down <= (btn == 2);
		left <= (btn == 3);
		right <= (btn == 4);
		place <= (btn == 5);
	endtask

	task automatic applyReset();
		@(posedge clk);
		rst <= 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk); // sInit clears the board here
	endtask

	task automatic closeTest();
		if (inTest)
		begin
			@(negedge clk);
			testsRun = testsRun + 1;
			if (errorTotal() == testErrStart)
			begin
				testsPassed = testsPassed + 1;
				$display("test %s: pass", testName);
			end
			else
				$display("test %s: fail", testName);
		end
	endtask

	// press for two cycles, release for two, then strobe the expected values
	task automatic playMove(input int btn, input logic [3:0] cur, input logic [8:0] xc,
		input logic [8:0] oc, input logic tv, input logic [1:0] st, input logic wv);
		@(posedge clk);
		driveButtons(btn);
		repeat (2) @(posedge clk);
		driveButtons(0);
		repeat (2) @(posedge clk);
		check <= 1'b1;
		expCursor <= cur;
		expX <= xc;
		expO <= oc;
		expTurn <= tv;
		expStatus <= st;
		expWinner <= wv;
		@(posedge clk);
		check <= 1'b0;
	endtask

	task automatic runLine(input string line);
		int n;
		int btn;
		logic [3:0] cur;
		logic [8:0] xc;
		logic [8:0] oc;
		logic tv;
		logic [1:0] st;
		logic wv;
		string name;
		if (line[0] == "t")
		begin
			n = $sscanf(line, "t %s", name);
			closeTest();
			if (n != 1)
			begin
				badLines = badLines + 1;
				$display("test header could not be read: %s", line);
			end
			testName = name;
			applyReset();
			testErrStart = errorTotal();
			inTest = 1;
		end
		else
		begin
			n = $sscanf(line, "m %d %d %h %h %d %d %d", btn, cur, xc, oc, tv, st, wv);
			if (n != 7)
			begin
				badLines = badLines + 1;
				$display("pattern line could not be read: %s", line);
			end
			else
				playMove(btn, cur, xc, oc, tv, st, wv);
		end
	endtask

	initial
	begin
		int fd;
		int rc;
		string line;
		rst = 1'b1;
		up = 1'b0;
		down = 1'b0;
		left = 1'b0;
		right = 1'b0;
		place = 1'b0;
		check = 1'b0;
		expCursor = '0;
		expX = '0;
		expO = '0;
		expTurn = 1'b0;
		expStatus = 2'd0;
		expWinner = 1'b0;
		fd = $fopen("test/tictac_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the pattern file test/tictac_patterns.txt");
			$display("Something failed");
			$finish;
		end
		else
		begin
			while (!$feof(fd))
			begin
				rc = $fgets(line, fd);
				if (rc > 0 && line.len() > 1 && line[0] != "#")
					lines.push_back(line);
			end
			$fclose(fd);
			limit = 8 * lines.size() + 40;
			foreach (lines[i])
				runLine(lines[i]);
			closeTest();
			$display("%0d tests, %0d passed, %0d failed, %0d mismatches, %0d assertion failures",
				testsRun, testsPassed, testsRun - testsPassed, mismatches,
				i_dut.i_check.failures);
			if (testsRun > 0 && testsPassed == testsRun && errorTotal() == 0)
				$display("Everything OK");
			else
				$display("Something failed");
			$finish;
		end
	end

endmodule

/* project.f */
+incdir+design
design/tictacPkg.sv
design/gameIf.sv
design/gameFsm.sv
design/cursorMover.sv
design/boardStore.sv
design/ticTacToeTop.sv
test/tictac_checker.sv
test/tictacMonitor.sv
test/tictacTb.sv

/* run.sh */
#!/bin/sh
# builds the tic-tac-toe testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tictacTb -f project.f -o tictacSim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

# the error limit keeps the run going after a failed assertion
output=$(./obj_dir/tictacSim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1

/* test/tictac_patterns.txt */
# t <name> resets the DUT and starts a test; m <button> <cursor> <xCells hex> <oCells hex> <turn> <status> <winner>
# button 0 none 1 up 2 down 3 left 4 right 5 place; status 0 playing 1 won 2 draw; marks 0 X 1 O
t wrap
m 0 4 000 000 0 0 0
m 4 5 000 000 0 0 0
m 4 3 000 000 0 0 0
m 4 4 000 000 0 0 0
m 4 5 000 000 0 0 0
m 1 8 000 000 0 0 0
m 3 7 000 000 0 0 0
m 1 1 000 000 0 0 0
m 2 7 000 000 0 0 0
m 3 6 000 000 0 0 0
m 1 0 000 000 0 0 0
m 3 2 000 000 0 0 0
t win
m 5 4 010 000 1 0 0
m 5 4 010 000 1 0 0
m 4 5 010 000 1 0 0
m 5 5 010 020 0 0 0
m 1 8 010 020 0 0 0
m 5 8 110 020 1 0 0
m 3 7 110 020 1 0 0
m 5 7 110 0a0 0 0 0
m 2 4 110 0a0 0 0 0
m 2 1 110 0a0 0 0 0
m 3 0 110 0a0 0 0 0
m 5 0 111 0a0 1 1 0
m 4 0 111 0a0 1 1 0
t draw
m 1 7 000 000 0 0 0
m 5 7 080 000 1 0 0
m 2 4 080 000 1 0 0
m 5 4 080 010 0 0 0
m 3 3 080 010 0 0 0
m 5 3 088 010 1 0 0
m 1 6 088 010 1 0 0
m 5 6 088 050 0 0 0
m 1 0 088 050 0 0 0
m 5 0 089 050 1 0 0
m 4 1 089 050 1 0 0
m 5 1 089 052 0 0 0
m 4 2 089 052 0 0 0
m 5 2 08d 052 1 0 0
m 1 5 08d 052 1 0 0
m 5 5 08d 072 0 0 0
m 1 8 08d 072 0 0 0
m 5 8 18d 072 1 2 0
